// ==== lsu_top.f ====
hdl/mem_bus_pkg.sv
hdl/lsu_pkg.sv
hdl/lsu_req_if.sv
hdl/lsu_issue_queue.sv
hdl/lsu_replay_queue.sv
hdl/lsu_pipe.sv
hdl/lsu_top.sv
verification/tb_clk_gen.sv
verification/lsu_assert.sv
verification/lsu_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := lsu_tb
FILELIST := lsu_top.f
FLAGS    := --binary --timing --assert -j 0
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
PASS_MSG := Simulation passed
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/lsu_testdata.txt ====
// columns: op (0 load, 1 store), addr, wdata, expected rdata, retries, error
// unknown memory reads as {~addr, addr}, no load touches a stored address
1 0100 11111111 00000000 0 0
0 0200 00000000 fdff0200 0 0
1 0104 22222222 00000000 2 0
0 0204 00000000 fdfb0204 1 0
0 0208 00000000 00000000 0 1
1 0108 33333333 00000000 0 0
0 020c 00000000 fdf3020c 0 0
0 0210 00000000 fdef0210 3 0
1 010c 44444444 00000000 1 0
1 0110 55555555 00000000 0 1
0 0214 00000000 fdeb0214 0 0
0 0218 00000000 fde70218 2 0
1 0114 66666666 00000000 0 0
0 021c 00000000 fde3021c 0 0
1 0118 77777777 00000000 1 0
0 0220 00000000 fddf0220 0 0
0 0224 00000000 fddb0224 1 0
1 011c 88888888 00000000 0 0
0 0228 00000000 00000000 0 1
1 0120 99999999 00000000 2 0
0 022c 00000000 fdd3022c 0 0
0 8000 00000000 7fff8000 0 0

// ==== verification/lsu_tb.sv ====
// LSU testbench
// Dispatches the operations of the data file, answers them as a Wishbone
// slave with retries and errors, and checks every done report

`timescale 1ns/1ps

module lsu_tb;

  localparam int NUM_OPS        = 22;
  localparam int FIELDS         = 6;
  localparam int COL_OP         = 0;
  localparam int COL_ADDR       = 1;
  localparam int COL_WDATA      = 2;
  localparam int COL_RDATA      = 3;
  localparam int COL_RTY        = 4;
  localparam int COL_ERR        = 5;
  // Forty cycles per operation is far above the slowest slave
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40;
  localparam int MEM_WORDS      = 1 << (mem_bus_pkg::ADDR_W - 2);

  logic clk;
  logic rst_n;

  logic                   disp_valid;
  lsu_pkg::lsu_op_e       disp_op;
  mem_bus_pkg::bus_addr_t disp_addr;
  mem_bus_pkg::bus_data_t disp_wdata;
  logic                   disp_ready;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  mem_bus_pkg::bus_addr_t wb_adr;
  mem_bus_pkg::bus_data_t wb_dat_out;
  mem_bus_pkg::bus_data_t wb_dat;
  logic                   wb_ack;
  logic                   wb_err;
  logic                   wb_rty;
  logic                   done_valid;
  lsu_pkg::lsu_tag_t      done_tag;
  mem_bus_pkg::bus_data_t done_rdata;
  logic                   done_err;

  logic [31:0]            td_words  [NUM_OPS * FIELDS];
  mem_bus_pkg::bus_data_t mem_model [MEM_WORDS];
  int rty_left [NUM_OPS];
  bit ended    [NUM_OPS];
  bit started  [NUM_OPS];

  int disp_idx;
  int started_cnt;
  int done_count;
  int cycle_cnt;
  int acc_wait;
  int acc_line;
  int done_line;
  bit acc_open;
  bit done_due;
  bit run_active;
  bit saw_full;

  tb_clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  lsu_top lsu_top_i (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_disp_valid (disp_valid),
    .i_disp_op    (disp_op),
    .i_disp_addr  (disp_addr),
    .i_disp_wdata (disp_wdata),
    .o_disp_ready (disp_ready),
    .o_wb_cyc     (wb_cyc),
    .o_wb_stb     (wb_stb),
    .o_wb_we      (wb_we),
    .o_wb_adr     (wb_adr),
    .o_wb_dat     (wb_dat_out),
    .i_wb_dat     (wb_dat),
    .i_wb_ack     (wb_ack),
    .i_wb_err     (wb_err),
    .i_wb_rty     (wb_rty),
    .o_done_valid (done_valid),
    .o_done_tag   (done_tag),
    .o_done_rdata (done_rdata),
    .o_done_err   (done_err)
  );

  function automatic logic [31:0] field(input int line, input int col);
    return td_words[line * FIELDS + col];
  endfunction

  function automatic int mem_index(input mem_bus_pkg::bus_addr_t addr);
    return int'(addr[mem_bus_pkg::ADDR_W-1:2]);
  endfunction

  // Every data line uses its own address
  function automatic int find_line(input mem_bus_pkg::bus_addr_t addr);
    int hit;
    hit = -1;
    for (int i = 0; i < NUM_OPS; i++) begin
      if (field(i, COL_ADDR) == 32'(addr)) begin
        hit = i;
      end
    end
    return hit;
  endfunction

  task automatic stop_on_error();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got_val);
    if (got_val !== exp_val) begin
      $display("Mismatch %s expected %h got %h", name, exp_val, got_val);
      stop_on_error();
    end
  endtask

  // ----------------------------------------
  // Done report, due one cycle after ack or err
  // ----------------------------------------
  task automatic check_done();
    if (done_valid) begin
      if (!done_due) begin
        $display("Done reported for tag %h although no access had ended", done_tag);
        stop_on_error();
      end
      check_value("o_done_tag", 32'(done_line % 16), 32'(done_tag));
      check_value("o_done_err", field(done_line, COL_ERR), 32'(done_err));
      check_value("o_done_rdata", field(done_line, COL_RDATA), done_rdata);
      done_count++;
      done_due = 1'b0;
    end else if (done_due) begin
      $display("No done report in the cycle after the access ended");
      stop_on_error();
    end
  endtask

  // ----------------------------------------
  // Wishbone slave with random delay
  // ----------------------------------------
  task automatic serve_bus();
    wb_ack = 1'b0;
    wb_err = 1'b0;
    wb_rty = 1'b0;
    wb_dat = '0;
    if (wb_cyc) begin
      check_value("o_wb_stb", 32'h1, 32'(wb_stb));
      if (!acc_open) begin
        acc_line = find_line(wb_adr);
        if (acc_line < 0) begin
          $display("Bus access to address %h that no operation uses", wb_adr);
          stop_on_error();
        end
        if (ended[acc_line]) begin
          $display("Address %h accessed again after its operation ended", wb_adr);
          stop_on_error();
        end
        check_value("o_wb_we", field(acc_line, COL_OP), 32'(wb_we));
        if (!started[acc_line]) begin
          started[acc_line] = 1'b1;
          started_cnt++;
        end
        acc_open = 1'b1;
        acc_wait = int'($urandom % 3);
      end
      if (acc_wait > 0) begin
        acc_wait--;
      end else begin
        acc_open = 1'b0;
        if (rty_left[acc_line] > 0) begin
          rty_left[acc_line]--;
          wb_rty = 1'b1;
        end else begin
          ended[acc_line] = 1'b1;
          done_due        = 1'b1;
          done_line       = acc_line;
          if (field(acc_line, COL_ERR) != 0) begin
            wb_err = 1'b1;
          end else if (wb_we) begin
            wb_ack = 1'b1;
            mem_model[mem_index(wb_adr)] = wb_dat_out;
          end else begin
            wb_ack = 1'b1;
            wb_dat = mem_model[mem_index(wb_adr)];
          end
        end
      end
    end else begin
      check_value("o_wb_stb", 32'h0, 32'(wb_stb));
    end
  endtask

  // One dispatch offered every cycle
  task automatic drive_dispatch();
    if (!disp_ready) begin
      saw_full = 1'b1;
      if ((disp_idx - started_cnt) < lsu_pkg::ISSUE_DEPTH) begin
        $display("o_disp_ready fell with %0d operations waiting", disp_idx - started_cnt);
        stop_on_error();
      end
    end
    if (disp_idx < NUM_OPS) begin
      disp_valid = 1'b1;
      disp_op    = lsu_pkg::lsu_op_e'(td_words[disp_idx * FIELDS + COL_OP][0]);
      disp_addr  = mem_bus_pkg::bus_addr_t'(field(disp_idx, COL_ADDR));
      disp_wdata = field(disp_idx, COL_WDATA);
      if (disp_ready) begin
        disp_idx++;
      end
    end else begin
      disp_valid = 1'b0;
    end
  endtask

  always @(negedge clk) begin
    if (run_active) begin
      check_done();
      serve_bus();
      drive_dispatch();
    end
  end

  always @(posedge clk) begin
    if (run_active) begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles with %0d of %0d operations done",
                 cycle_cnt, done_count, NUM_OPS);
        stop_on_error();
      end
    end
  end

  initial begin
    disp_valid = 1'b0;
    disp_op    = lsu_pkg::LSU_LOAD;
    disp_addr  = '0;
    disp_wdata = '0;
    wb_dat     = '0;
    wb_ack     = 1'b0;
    wb_err     = 1'b0;
    wb_rty     = 1'b0;
    void'($urandom(32'he065_56ef));
    $readmemh("verification/lsu_testdata.txt", td_words);
    // Fill pattern {~addr, addr} over the whole byte address
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = {~mem_bus_pkg::bus_addr_t'(i << 2), mem_bus_pkg::bus_addr_t'(i << 2)};
    end
    for (int i = 0; i < NUM_OPS; i++) begin
      rty_left[i] = int'(field(i, COL_RTY));
    end
    @(posedge rst_n);
    @(posedge clk);
    run_active = 1'b1;
    wait (done_count == NUM_OPS);
    @(posedge clk);
    // Each store must have left its data in the memory model
    for (int i = 0; i < NUM_OPS; i++) begin
      if (field(i, COL_OP) == 1 && field(i, COL_ERR) == 0) begin
        check_value("o_wb_dat", field(i, COL_WDATA),
                    mem_model[mem_index(mem_bus_pkg::bus_addr_t'(field(i, COL_ADDR)))]);
      end
    end
    if (done_count == NUM_OPS && saw_full) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Issue queue never filled while dispatching every cycle");
      stop_on_error();
    end
  end

endmodule

// ==== verification/lsu_assert.sv ====
// LSU pipeline assertions
// Wishbone handshake and done report rules, bound into lsu_pipe

`timescale 1ns/1ps

module lsu_assert (
  input logic                   i_clk,
  input logic                   i_rst_n,
  input logic                   i_wb_cyc,
  input logic                   i_wb_stb,
  input mem_bus_pkg::bus_addr_t i_wb_adr,
  input logic                   i_wb_ack,
  input logic                   i_wb_err,
  input logic                   i_wb_rty,
  input logic                   i_done_valid,
  input lsu_pkg::lsu_tag_t      i_done_tag
);

  logic w_term;

  assign w_term = i_wb_ack || i_wb_err || i_wb_rty;

  // A terminated access closes in the following cycle
  cyc_ends_after_term: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_wb_cyc && w_term) |=> !(i_wb_cyc || i_wb_stb))
    else $error("wb cycle still open after its termination");

  // Address holds until the slave ends the access
  adr_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_wb_stb && !w_term) |=> $stable(i_wb_adr))
    else $error("wb address changed during an open access");

  done_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_done_valid |=> !(i_done_valid && (i_done_tag == $past(i_done_tag))))
    else $error("done report held two cycles for one tag");

endmodule

bind lsu_pipe lsu_assert u_lsu_assert (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_wb_cyc     (o_wb_cyc),
  .i_wb_stb     (o_wb_stb),
  .i_wb_adr     (o_wb_adr),
  .i_wb_ack     (i_wb_ack),
  .i_wb_err     (i_wb_err),
  .i_wb_rty     (i_wb_rty),
  .i_done_valid (o_done_valid),
  .i_done_tag   (o_done_tag)
);

// ==== verification/tb_clk_gen.sv ====
// Testbench clock and reset
// 20 ns clock, active low reset held for 16 cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  // Released on a falling edge like every other input
  initial begin
    o_rst_n = 1'b0;
    repeat (16) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

// ==== hdl/lsu_top.sv ====
// LSU top level
// Issue queue, replay queue and pipeline behind plain dispatch,
// Wishbone and done ports

`timescale 1ns/1ps

module lsu_top (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_disp_valid,
  input  lsu_pkg::lsu_op_e       i_disp_op,
  input  mem_bus_pkg::bus_addr_t i_disp_addr,
  input  mem_bus_pkg::bus_data_t i_disp_wdata,
  output logic                   o_disp_ready,
  output logic                   o_wb_cyc,
  output logic                   o_wb_stb,
  output logic                   o_wb_we,
  output mem_bus_pkg::bus_addr_t o_wb_adr,
  output mem_bus_pkg::bus_data_t o_wb_dat,
  input  mem_bus_pkg::bus_data_t i_wb_dat,
  input  logic                   i_wb_ack,
  input  logic                   i_wb_err,
  input  logic                   i_wb_rty,
  output logic                   o_done_valid,
  output lsu_pkg::lsu_tag_t      o_done_tag,
  output mem_bus_pkg::bus_data_t o_done_rdata,
  output logic                   o_done_err
);

  lsu_req_if w_iss_req ();
  lsu_req_if w_rpl_req ();
  lsu_req_if w_rpl_push ();

  logic w_near_full;

  lsu_issue_queue u_issue_queue (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_disp_valid (i_disp_valid),
    .i_disp_op    (i_disp_op),
    .i_disp_addr  (i_disp_addr),
    .i_disp_wdata (i_disp_wdata),
    .o_disp_ready (o_disp_ready),
    .i_hold       (w_near_full),
    .req          (w_iss_req)
  );

  lsu_replay_queue u_replay_queue (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .push        (w_rpl_push),
    .req         (w_rpl_req),
    .o_near_full (w_near_full)
  );

  lsu_pipe u_lsu_pipe (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .iss          (w_iss_req),
    .rpl          (w_rpl_req),
    .push         (w_rpl_push),
    .o_wb_cyc     (o_wb_cyc),
    .o_wb_stb     (o_wb_stb),
    .o_wb_we      (o_wb_we),
    .o_wb_adr     (o_wb_adr),
    .o_wb_dat     (o_wb_dat),
    .i_wb_dat     (i_wb_dat),
    .i_wb_ack     (i_wb_ack),
    .i_wb_err     (i_wb_err),
    .i_wb_rty     (i_wb_rty),
    .o_done_valid (o_done_valid),
    .o_done_tag   (o_done_tag),
    .o_done_rdata (o_done_rdata),
    .o_done_err   (o_done_err)
  );

endmodule

// ==== hdl/lsu_pipe.sv ====
// LSU pipeline
// ex0 picks the older queue head, ex1 runs one Wishbone classic access,
// ex2 reports completion

`timescale 1ns/1ps

module lsu_pipe (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  lsu_req_if.sink                iss,
  lsu_req_if.sink                rpl,
  lsu_req_if.src                 push,
  output logic                   o_wb_cyc,
  output logic                   o_wb_stb,
  output logic                   o_wb_we,
  output mem_bus_pkg::bus_addr_t o_wb_adr,
  output mem_bus_pkg::bus_data_t o_wb_dat,
  input  mem_bus_pkg::bus_data_t i_wb_dat,
  input  logic                   i_wb_ack,
  input  logic                   i_wb_err,
  input  logic                   i_wb_rty,
  output logic                   o_done_valid,
  output lsu_pkg::lsu_tag_t      o_done_tag,
  output mem_bus_pkg::bus_data_t o_done_rdata,
  output logic                   o_done_err
);

  logic                   r_ex0_valid;
  lsu_pkg::lsu_tag_t      r_ex0_tag;
  lsu_pkg::lsu_op_e       r_ex0_op;
  mem_bus_pkg::bus_addr_t r_ex0_addr;
  mem_bus_pkg::bus_data_t r_ex0_wdata;

  lsu_pkg::ex1_state_e    r_ex1_state;
  lsu_pkg::lsu_tag_t      r_ex1_tag;
  lsu_pkg::lsu_op_e       r_ex1_op;
  mem_bus_pkg::bus_addr_t r_ex1_addr;
  mem_bus_pkg::bus_data_t r_ex1_wdata;

  logic w_rpl_pick;
  logic w_ex0_open;
  logic w_ex0_take;
  logic w_ex1_take;
  logic w_term;
  logic w_done;

  // ---------------------------------------
  // ex0 selection
  // ---------------------------------------
  assign w_rpl_pick = rpl.valid && (!iss.valid || lsu_pkg::tag_older(rpl.tag, iss.tag));
  assign w_ex1_take = r_ex0_valid && (r_ex1_state == lsu_pkg::EX1_IDLE);
  assign w_ex0_open = !r_ex0_valid || w_ex1_take;

  assign rpl.ready  = w_ex0_open && w_rpl_pick;
  assign iss.ready  = w_ex0_open && !w_rpl_pick && iss.valid;
  assign w_ex0_take = rpl.ready || iss.ready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_ex0_valid <= 1'b0;
    end else if (w_ex0_open) begin
      r_ex0_valid <= w_ex0_take;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_ex0_take) begin
      r_ex0_tag   <= w_rpl_pick ? rpl.tag   : iss.tag;
      r_ex0_op    <= w_rpl_pick ? rpl.op    : iss.op;
      r_ex0_addr  <= w_rpl_pick ? rpl.addr  : iss.addr;
      r_ex0_wdata <= w_rpl_pick ? rpl.wdata : iss.wdata;
    end
  end

  // ---------------------------------------
  // ex1 Wishbone classic access
  // ---------------------------------------
  assign o_wb_cyc = (r_ex1_state == lsu_pkg::EX1_BUS);
  assign o_wb_stb = (r_ex1_state == lsu_pkg::EX1_BUS);
  assign o_wb_we  = (r_ex1_op == lsu_pkg::LSU_STORE);
  assign o_wb_adr = r_ex1_addr;
  assign o_wb_dat = r_ex1_wdata;

  assign w_term = o_wb_cyc && (i_wb_ack || i_wb_err || i_wb_rty);
  assign w_done = o_wb_cyc && (i_wb_ack || i_wb_err);

  // Retry goes back to the replay queue on the terminating edge
  assign push.valid = o_wb_cyc && i_wb_rty && !i_wb_ack && !i_wb_err;
  assign push.tag   = r_ex1_tag;
  assign push.op    = r_ex1_op;
  assign push.addr  = r_ex1_addr;
  assign push.wdata = r_ex1_wdata;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_ex1_state <= lsu_pkg::EX1_IDLE;
    end else begin
      case (r_ex1_state)
        lsu_pkg::EX1_IDLE: if (r_ex0_valid) r_ex1_state <= lsu_pkg::EX1_BUS;
        lsu_pkg::EX1_BUS:  if (w_term) r_ex1_state <= lsu_pkg::EX1_IDLE;
        default:           r_ex1_state <= lsu_pkg::EX1_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_ex1_take) begin
      r_ex1_tag   <= r_ex0_tag;
      r_ex1_op    <= r_ex0_op;
      r_ex1_addr  <= r_ex0_addr;
      r_ex1_wdata <= r_ex0_wdata;
    end
  end

  // ---------------------------------------
  // ex2 done report
  // ---------------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_done_valid <= 1'b0;
    end else begin
      o_done_valid <= w_done;
    end
  end

  // Read data only for a load that was acked
  always_ff @(posedge i_clk) begin
    if (w_done) begin
      o_done_tag   <= r_ex1_tag;
      o_done_err   <= !i_wb_ack;
      o_done_rdata <= (i_wb_ack && (r_ex1_op == lsu_pkg::LSU_LOAD)) ? i_wb_dat : '0;
    end
  end

endmodule

// ==== hdl/lsu_replay_queue.sv ====
// LSU replay queue
// Keeps operations refused with a bus retry and offers the oldest one

`timescale 1ns/1ps

module lsu_replay_queue (
  input  logic    i_clk,
  input  logic    i_rst_n,
  lsu_req_if.sink push,
  lsu_req_if.src  req,
  output logic    o_near_full
);

  logic [lsu_pkg::REPLAY_DEPTH-1:0] r_slot_valid;
  lsu_pkg::lsu_tag_t      r_tag   [lsu_pkg::REPLAY_DEPTH];
  lsu_pkg::lsu_op_e       r_op    [lsu_pkg::REPLAY_DEPTH];
  mem_bus_pkg::bus_addr_t r_addr  [lsu_pkg::REPLAY_DEPTH];
  mem_bus_pkg::bus_data_t r_wdata [lsu_pkg::REPLAY_DEPTH];

  // Offered slot is frozen while it waits for the pipeline
  logic              r_held;
  lsu_pkg::rpl_idx_t r_held_idx;

  lsu_pkg::rpl_idx_t w_free_idx;
  lsu_pkg::rpl_cnt_t w_free_cnt;
  lsu_pkg::rpl_idx_t w_old_idx;
  logic              w_old_found;
  lsu_pkg::rpl_idx_t w_sel_idx;
  logic              w_push;
  logic              w_pop;

  // Lowest free slot and number of free slots
  always_comb begin
    w_free_idx = '0;
    w_free_cnt = '0;
    for (int i = lsu_pkg::REPLAY_DEPTH - 1; i >= 0; i--) begin
      if (!r_slot_valid[i]) begin
        w_free_idx = lsu_pkg::rpl_idx_t'(i);
        w_free_cnt = w_free_cnt + 1'b1;
      end
    end
  end

  // Oldest valid slot by wrapping tag age
  always_comb begin
    w_old_idx   = '0;
    w_old_found = 1'b0;
    for (int i = 0; i < lsu_pkg::REPLAY_DEPTH; i++) begin
      if (r_slot_valid[i] &&
          (!w_old_found || lsu_pkg::tag_older(r_tag[i], r_tag[w_old_idx]))) begin
        w_old_idx   = lsu_pkg::rpl_idx_t'(i);
        w_old_found = 1'b1;
      end
    end
  end

  assign w_sel_idx  = r_held ? r_held_idx : w_old_idx;
  assign push.ready = (w_free_cnt != '0);
  assign w_push     = push.valid && push.ready;
  assign w_pop      = req.valid && req.ready;

  assign req.valid = w_old_found;
  assign req.tag   = r_tag[w_sel_idx];
  assign req.op    = r_op[w_sel_idx];
  assign req.addr  = r_addr[w_sel_idx];
  assign req.wdata = r_wdata[w_sel_idx];

  // Counts a retry landing this cycle, so ex0 and ex1 always find room
  assign o_near_full = (w_free_cnt < lsu_pkg::rpl_cnt_t'(2)) ||
                       (push.valid && (w_free_cnt == lsu_pkg::rpl_cnt_t'(2)));

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_slot_valid <= '0;
      r_held       <= 1'b0;
      r_held_idx   <= '0;
    end else begin
      if (w_pop) begin
        r_slot_valid[w_sel_idx] <= 1'b0;
      end
      if (w_push) begin
        r_slot_valid[w_free_idx] <= 1'b1;
      end
      r_held     <= req.valid && !req.ready;
      r_held_idx <= w_sel_idx;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_tag[w_free_idx]   <= push.tag;
      r_op[w_free_idx]    <= push.op;
      r_addr[w_free_idx]  <= push.addr;
      r_wdata[w_free_idx] <= push.wdata;
    end
  end

endmodule

// ==== hdl/lsu_issue_queue.sv ====
// LSU issue queue
// In-order FIFO of dispatched operations, tags them and offers the head

`timescale 1ns/1ps

module lsu_issue_queue (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_disp_valid,
  input  lsu_pkg::lsu_op_e       i_disp_op,
  input  mem_bus_pkg::bus_addr_t i_disp_addr,
  input  mem_bus_pkg::bus_data_t i_disp_wdata,
  output logic                   o_disp_ready,
  input  logic                   i_hold,
  lsu_req_if.src                 req
);

  lsu_pkg::lsu_op_e       r_op    [lsu_pkg::ISSUE_DEPTH];
  lsu_pkg::lsu_tag_t      r_tag   [lsu_pkg::ISSUE_DEPTH];
  mem_bus_pkg::bus_addr_t r_addr  [lsu_pkg::ISSUE_DEPTH];
  mem_bus_pkg::bus_data_t r_wdata [lsu_pkg::ISSUE_DEPTH];

  lsu_pkg::iss_idx_t r_wr_ptr;
  lsu_pkg::iss_idx_t r_rd_ptr;
  lsu_pkg::iss_cnt_t r_count;
  lsu_pkg::lsu_tag_t r_next_tag;

  logic w_push;
  logic w_pop;

  assign o_disp_ready = (r_count != lsu_pkg::iss_cnt_t'(lsu_pkg::ISSUE_DEPTH));
  assign w_push       = i_disp_valid && o_disp_ready;
  assign w_pop        = req.valid && req.ready;

  // Head is withheld while the replay queue is close to full
  assign req.valid = (r_count != '0) && !i_hold;
  assign req.tag   = r_tag[r_rd_ptr];
  assign req.op    = r_op[r_rd_ptr];
  assign req.addr  = r_addr[r_rd_ptr];
  assign req.wdata = r_wdata[r_rd_ptr];

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_wr_ptr   <= '0;
      r_rd_ptr   <= '0;
      r_count    <= '0;
      r_next_tag <= '0;
    end else begin
      if (w_push) begin
        r_wr_ptr   <= r_wr_ptr + 1'b1;
        r_next_tag <= r_next_tag + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      case ({w_push, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_op[r_wr_ptr]    <= i_disp_op;
      r_tag[r_wr_ptr]   <= r_next_tag;
      r_addr[r_wr_ptr]  <= i_disp_addr;
      r_wdata[r_wr_ptr] <= i_disp_wdata;
    end
  end

endmodule

// ==== hdl/lsu_req_if.sv ====
// Pipe request interface
// One candidate memory operation offered by a queue to the LSU pipeline

`timescale 1ns/1ps

interface lsu_req_if ();

  logic                   valid;
  logic                   ready;
  lsu_pkg::lsu_tag_t      tag;
  lsu_pkg::lsu_op_e       op;
  mem_bus_pkg::bus_addr_t addr;
  mem_bus_pkg::bus_data_t wdata;

  // Queue side presents the operation
  modport src (
    output valid, tag, op, addr, wdata,
    input  ready
  );

  // Pipeline side accepts it
  modport sink (
    input  valid, tag, op, addr, wdata,
    output ready
  );

endinterface

// ==== hdl/lsu_pkg.sv ====
// Load/store unit package
// Operation kinds, age tags, queue depths and pipeline state types

package lsu_pkg;

  localparam int TAG_W        = 4;
  localparam int ISSUE_DEPTH  = 4;
  localparam int REPLAY_DEPTH = 4;

  localparam int ISSUE_IDX_W  = $clog2(ISSUE_DEPTH);
  localparam int REPLAY_IDX_W = $clog2(REPLAY_DEPTH);

  // Largest forward distance still treated as younger
  localparam int AGE_SPAN = (1 << (TAG_W - 1)) - 1;

  typedef logic [TAG_W-1:0]        lsu_tag_t;
  typedef logic [ISSUE_IDX_W-1:0]  iss_idx_t;
  typedef logic [ISSUE_IDX_W:0]    iss_cnt_t;
  typedef logic [REPLAY_IDX_W-1:0] rpl_idx_t;
  typedef logic [REPLAY_IDX_W:0]   rpl_cnt_t;

  typedef enum logic {LSU_LOAD, LSU_STORE} lsu_op_e;

  typedef enum logic {EX1_IDLE, EX1_BUS} ex1_state_e;

  // True when tag a was dispatched before tag b
  function automatic logic tag_older(input lsu_tag_t a, input lsu_tag_t b);
    lsu_tag_t diff;
    diff = b - a;
    return (diff != '0) && (diff <= lsu_tag_t'(AGE_SPAN));
  endfunction

endpackage

// ==== hdl/mem_bus_pkg.sv ====
// Memory bus package
// Address and data widths of the Wishbone classic port

package mem_bus_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // Byte address, whole-word accesses only
  typedef logic [ADDR_W-1:0] bus_addr_t;

  typedef logic [DATA_W-1:0] bus_data_t;

endpackage
